/* Makefile */
TOP := tb_px
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -Mdir $(OBJ) -f verilog.f

run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf $(OBJ) sim.log

/* design/px.sv */
// P-X state control unit
module px (
	input  logic                    got,
	input  logic                    clo_,
	input  logic                    start,
	input  px_state_pkg::px_instr_t instr,
	input  logic                    irq,
	input  logic                    ok,
	input  logic                    en,
	output px_state_pkg::px_state_e state,
	output logic                    busy,
	output logic                    done,
	output logic                    strob1,
	output logic                    strob2,
	output px_bus_pkg::px_bus_req_t bus_req,
	output logic                    alarm,
	output logic                    nomem
);

	logic                    enter;	// First cycle of a state
	logic                    advance;	// Leave the state at next edge
	logic                    abort;	// Bus timed out
	logic                    bus_done;	// Bus answer captured
	logic                    irq_go;	// Interrupt sequence wanted
	px_state_pkg::px_state_e irq_next;

	px_state_reg state_reg_i (
		.got(got), .clo_(clo_), .start(start), .instr(instr),
		.advance(advance), .abort(abort), .irq_go(irq_go), .irq_next(irq_next),
		.state(state), .enter(enter), .busy(busy), .done(done)
	);

	px_irq_phase irq_phase_i (
		.got(got), .clo_(clo_), .irq(irq), .state(state), .enter(enter),
		.irq_go(irq_go), .irq_next(irq_next)
	);

	px_strobe strobe_i (
		.got(got), .clo_(clo_), .state(state), .enter(enter), .bus_done(bus_done),
		.strob1(strob1), .strob2(strob2), .advance(advance)
	);

	px_bus_ctl bus_ctl_i (
		.got(got), .clo_(clo_), .state(state), .enter(enter), .ok(ok), .en(en),
		.bus_req(bus_req), .bus_done(bus_done), .abort(abort),
		.alarm(alarm), .nomem(nomem)
	);

endmodule

/* design/px_bus_ctl.sv */
// P-X system bus request control
module px_bus_ctl (
	input  logic                    got,
	input  logic                    clo_,
	input  px_state_pkg::px_state_e state,
	input  logic                    enter,
	input  logic                    ok,	// Memory answered
	input  logic                    en,	// No memory at address
	output px_bus_pkg::px_bus_req_t bus_req,
	output logic                    bus_done,	// Answer taken at last edge
	output logic                    abort,	// Timeout pulse
	output logic                    alarm,	// Sticky timeout flag
	output logic                    nomem	// Sticky no-memory flag
);

	px_bus_pkg::px_tmo_t wait_cnt;
	px_bus_pkg::px_tmo_t wait_now;	// Wait count as seen this cycle
	logic                bus_st;	// State uses the bus
	logic                served;	// Request already ended
	logic                zg;
	logic                answer;
	logic                expire;

	always_comb begin
		bus_st = 1'b1;
		bus_req.wr = 1'b0;
		bus_req.src = px_bus_pkg::SRC_IC;
		case (state)
			px_state_pkg::S_P1,
			px_state_pkg::S_K2: bus_req.src = px_bus_pkg::SRC_IC;	// Fetch via IC
			px_state_pkg::S_WR: bus_req.src = px_bus_pkg::SRC_AR;
			px_state_pkg::S_WW: begin
				bus_req.wr = 1'b1;
				bus_req.src = px_bus_pkg::SRC_AR;
			end
			px_state_pkg::S_I2,
			px_state_pkg::S_I3,
			px_state_pkg::S_I4: begin
				bus_req.wr = 1'b1;	// Save to stack
				bus_req.src = px_bus_pkg::SRC_STACK;
			end
			px_state_pkg::S_I5: bus_req.src = px_bus_pkg::SRC_VECTOR;
			default:            bus_st = 1'b0;	// Idle, K1, I1
		endcase
	end

	assign zg = bus_st & (enter | ~served);	// Up from first cycle of the state
	assign bus_req.zg = zg;
	assign answer = zg & (ok | en);	// Answers outside a request are dropped

	assign wait_now = enter ? '0 : wait_cnt;
	assign expire = zg & ~answer
		& (wait_now == px_bus_pkg::BUS_TIMEOUT - px_bus_pkg::px_tmo_t'(1));

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			served <= 1'b0;
			wait_cnt <= '0;
			bus_done <= 1'b0;
			abort <= 1'b0;
			alarm <= 1'b0;
			nomem <= 1'b0;
		end else begin
			if (answer | expire) served <= 1'b1;	// Drop zg
			else if (enter) served <= 1'b0;
			wait_cnt <= zg ? wait_now + px_bus_pkg::px_tmo_t'(1) : '0;
			bus_done <= answer;
			abort <= expire;
			if (answer & en) nomem <= 1'b1;	// Kept until clo_
			if (expire) alarm <= 1'b1;	// Kept until clo_
		end
	end

endmodule

/* design/px_bus_pkg.sv */
// P-X system bus definitions
package px_bus_pkg;

	// Where the address for a bus cycle comes from
	typedef enum logic [1:0] {
		SRC_IC     = 2'd0,	// Instruction counter
		SRC_AR     = 2'd1,	// Argument register
		SRC_STACK  = 2'd2,	// Stack pointer
		SRC_VECTOR = 2'd3	// Interrupt vector
	} px_src_e;

	// Request as seen on the system bus
	typedef struct packed {
		logic    zg;	// Bus request
		logic    wr;	// Write cycle when set
		px_src_e src;	// Address source
	} px_bus_req_t;

	// Wait counter while zg is up
	typedef logic [4:0] px_tmo_t;

	// Cycles zg may stay up before the alarm
	localparam px_tmo_t BUS_TIMEOUT = 5'd16;

endpackage

/* design/px_irq_phase.sv */
// P-X interrupt phase control
module px_irq_phase (
	input  logic                    got,
	input  logic                    clo_,
	input  logic                    irq,	// Request pulse
	input  px_state_pkg::px_state_e state,
	input  logic                    enter,
	output logic                    irq_go,	// Start the I1..I5 sequence
	output px_state_pkg::px_state_e irq_next	// Phase after the current one
);

	logic pending;	// Request not yet acknowledged
	logic in_irq;	// Sequence running
	logic ack;	// First cycle of I1

	assign in_irq = state inside {
		px_state_pkg::S_I1,
		px_state_pkg::S_I2,
		px_state_pkg::S_I3,
		px_state_pkg::S_I4,
		px_state_pkg::S_I5
	};

	assign ack = enter & (state == px_state_pkg::S_I1);

	// New request has priority, so one arriving on acknowledge waits for the next round
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			pending <= 1'b0;
		end else if (irq) begin
			pending <= 1'b1;
		end else if (ack) begin
			pending <= 1'b0;	// Taken by this sequence
		end
	end

	assign irq_go = pending & ~in_irq;	// Held off until the sequence is over

	always_comb begin
		case (state)
			px_state_pkg::S_I1: irq_next = px_state_pkg::S_I2;	// Ack done
			px_state_pkg::S_I2: irq_next = px_state_pkg::S_I3;
			px_state_pkg::S_I3: irq_next = px_state_pkg::S_I4;
			px_state_pkg::S_I4: irq_next = px_state_pkg::S_I5;	// Stack saved
			default:            irq_next = px_state_pkg::S_IDLE;	// After vector read
		endcase
	end

endmodule

/* design/px_state_pkg.sv */
// P-X cycle state definitions
package px_state_pkg;

	// Control unit states, one instruction or interrupt phase each
	typedef enum logic [3:0] {
		S_IDLE = 4'd0,	// Waiting for start or interrupt
		S_P1   = 4'd1,	// Instruction fetch
		S_K1   = 4'd2,	// Decode
		S_K2   = 4'd3,	// Argument fetch
		S_WR   = 4'd4,	// Operand read
		S_WW   = 4'd5,	// Operand write
		S_I1   = 4'd6,	// Interrupt acknowledge
		S_I2   = 4'd7,	// Stack write 1
		S_I3   = 4'd8,	// Stack write 2
		S_I4   = 4'd9,	// Stack write 3
		S_I5   = 4'd10	// Vector read
	} px_state_e;

	// Operand access done after decode or argument fetch
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,	// No operand cycle
		OP_READ  = 2'd1,	// WR follows
		OP_WRITE = 2'd2	// WW follows
	} px_mem_op_e;

	// What the decoder tells the sequencer about one instruction
	typedef struct packed {
		logic       arg;	// Argument word follows in K2
		px_mem_op_e op;	// Operand access kind
	} px_instr_t;

	// Countdown for fixed-length states
	typedef logic [1:0] px_delay_t;

	localparam px_delay_t K1_DELAY = 2'd2;	// Decode time in got cycles
	localparam px_delay_t I1_DELAY = 2'd3;	// Acknowledge time in got cycles

endpackage

/* design/px_state_reg.sv */
// P-X state register and sequencer
module px_state_reg (
	input  logic                    got,
	input  logic                    clo_,
	input  logic                    start,	// Begin an instruction
	input  px_state_pkg::px_instr_t instr,	// Valid with start
	input  logic                    advance,	// Current state is finishing
	input  logic                    abort,	// Bus timeout
	input  logic                    irq_go,	// Interrupt waiting
	input  px_state_pkg::px_state_e irq_next,	// Successor inside I1..I5
	output px_state_pkg::px_state_e state,
	output logic                    enter,	// First cycle of a state
	output logic                    busy,
	output logic                    done
);

	px_state_pkg::px_instr_t instr_q;	// Descriptor of running instruction
	px_state_pkg::px_state_e nxt;
	px_state_pkg::px_state_e end_st;	// Where an instruction goes when over
	px_state_pkg::px_state_e op_st;	// State after decode or argument
	logic                    take;	// State changes at next edge
	logic                    accept;	// Start taken this cycle
	logic                    final_st;	// Last state of the instruction

	always_comb begin
		end_st = irq_go ? px_state_pkg::S_I1 : px_state_pkg::S_IDLE;	// Interrupt wins over idle
		case (instr_q.op)
			px_state_pkg::OP_READ:  op_st = px_state_pkg::S_WR;
			px_state_pkg::OP_WRITE: op_st = px_state_pkg::S_WW;
			default:                op_st = end_st;	// No operand cycle
		endcase
	end

	assign accept = (state == px_state_pkg::S_IDLE) & ~irq_go & start;

	always_comb begin
		take = 1'b0;
		nxt = state;
		if (abort) begin
			take = 1'b1;
			nxt = px_state_pkg::S_IDLE;	// Dead bus ends the sequence
		end else if (state == px_state_pkg::S_IDLE) begin
			if (irq_go) begin
				take = 1'b1;
				nxt = px_state_pkg::S_I1;
			end else if (start) begin
				take = 1'b1;
				nxt = px_state_pkg::S_P1;
			end
		end else if (advance) begin
			take = 1'b1;
			case (state)
				px_state_pkg::S_P1: nxt = px_state_pkg::S_K1;
				px_state_pkg::S_K1: nxt = instr_q.arg ? px_state_pkg::S_K2 : op_st;
				px_state_pkg::S_K2: nxt = op_st;
				px_state_pkg::S_WR,
				px_state_pkg::S_WW: nxt = end_st;
				default:            nxt = irq_next;	// I1..I5 chain
			endcase
		end
	end

	// Instruction ends in WR, WW, or earlier when nothing more is needed
	assign final_st = (state == px_state_pkg::S_WR) | (state == px_state_pkg::S_WW)
		| ((state == px_state_pkg::S_K2) & (instr_q.op == px_state_pkg::OP_NONE))
		| ((state == px_state_pkg::S_K1) & ~instr_q.arg
			& (instr_q.op == px_state_pkg::OP_NONE));

	assign done = advance & final_st;
	assign busy = (state != px_state_pkg::S_IDLE);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= px_state_pkg::S_IDLE;
			enter <= 1'b0;
		end else begin
			state <= nxt;
			enter <= take;	// Marks first cycle of new state
		end
	end

	always_ff @(posedge got) begin
		if (accept) instr_q <= instr;	// Held for the whole instruction
	end

endmodule

/* design/px_strobe.sv */
// P-X strobe generator
module px_strobe (
	input  logic                    got,
	input  logic                    clo_,
	input  px_state_pkg::px_state_e state,
	input  logic                    enter,
	input  logic                    bus_done,	// Answer captured last edge
	output logic                    strob1,
	output logic                    strob2,
	output logic                    advance	// Last cycle of the state
);

	px_state_pkg::px_delay_t load;	// Length of a timed state
	px_state_pkg::px_delay_t left;	// Cycles remaining incl. this one
	px_state_pkg::px_delay_t cnt;
	logic                    timed;	// State runs on a fixed delay
	logic                    last;	// Timed state ends here
	logic                    s2_q;

	always_comb begin
		timed = 1'b1;
		load = px_state_pkg::K1_DELAY;
		case (state)
			px_state_pkg::S_K1: load = px_state_pkg::K1_DELAY;
			px_state_pkg::S_I1: load = px_state_pkg::I1_DELAY;
			default:            timed = 1'b0;	// Bus states wait for an answer
		endcase
	end

	assign left = enter ? load : cnt;	// Fresh count on state entry
	assign last = timed & (left == px_state_pkg::px_delay_t'(1));

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cnt <= '0;
			s2_q <= 1'b0;
		end else begin
			if (timed) cnt <= left - px_state_pkg::px_delay_t'(1);
			s2_q <= ~timed & bus_done;	// strob2 trails strob1 by one
		end
	end

	// Timed states give only strob1, bus states give both after the answer
	assign strob1 = timed ? last : bus_done;
	assign strob2 = s2_q;
	assign advance = timed ? last : s2_q;

endmodule

/* tb/px_sva.sv */
// P-X strobe and bus request checks
module px_sva (
	input logic                    got,
	input logic                    clo_,
	input px_state_pkg::px_state_e state,
	input logic                    strob1,
	input logic                    strob2,
	input logic                    zg,
	input logic                    done
);

	int   zg_run;	// zg cycles before this one
	int   n_order = 0;	// Failure counts, read from the testbench
	int   n_zg = 0;
	int   n_done = 0;
	logic bus_st;

	assign bus_st = !(state inside {px_state_pkg::S_IDLE, px_state_pkg::S_K1,
		px_state_pkg::S_I1});	// Everything else waits on the bus

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) zg_run <= 0;
		else if (zg) zg_run <= zg_run + 1;
		else zg_run <= 0;	// Request ended
	end

	strob_order: assert property (@(posedge got) disable iff (!clo_)
			strob1 && bus_st |=> strob2)
		else begin
			n_order++;
			$error("strob2 did not follow strob1 in a bus state");
		end

	zg_limit: assert property (@(posedge got) disable iff (!clo_)
			zg |-> zg_run < int'(px_bus_pkg::BUS_TIMEOUT))
		else begin
			n_zg++;
			$error("zg held past the bus timeout");
		end

	// Timed states end on strob1, bus states on strob2
	done_strobe: assert property (@(posedge got) disable iff (!clo_)
			done |-> (bus_st ? strob2 : strob1))
		else begin
			n_done++;
			$error("done without the closing strobe");
		end

endmodule

bind px px_sva sva_i (
	.got(got), .clo_(clo_), .state(state), .strob1(strob1), .strob2(strob2),
	.zg(bus_req.zg), .done(done)
);

/* tb/tb_px.sv */
// P-X control unit testbench
module tb_px;

	logic                    got;
	logic                    clo_;
	logic                    start;
	px_state_pkg::px_instr_t instr;
	logic                    irq;
	logic                    ok;
	logic                    en;
	px_state_pkg::px_state_e state;
	logic                    busy;
	logic                    done;
	logic                    strob1;
	logic                    strob2;
	px_bus_pkg::px_bus_req_t bus_req;
	logic                    alarm;
	logic                    nomem;

	integer seed = 32'h1f9e9986;	// Fixed stimulus seed
	int     errors = 0;
	int     tests_run = 0;
	int     tests_bad = 0;
	string  cur_test;
	int     dly_lo;	// Answer delay range in zg cycles
	int     dly_hi;
	bit     use_en;	// Answer with en instead of ok
	bit     exp_alarm;	// Model of the sticky flags
	bit     exp_nomem;

	px px_i (
		.got(got), .clo_(clo_), .start(start), .instr(instr), .irq(irq), .ok(ok), .en(en),
		.state(state), .busy(busy), .done(done), .strob1(strob1), .strob2(strob2),
		.bus_req(bus_req), .alarm(alarm), .nomem(nomem)
	);

	always #50 got = ~got;	// 100 unit period

	// Request a state should raise, wr in bit 2 above src, -1 for none
	function automatic int expected_req(input px_state_pkg::px_state_e s);
		case (s)
			px_state_pkg::S_P1,
			px_state_pkg::S_K2: return int'(px_bus_pkg::SRC_IC);
			px_state_pkg::S_WR: return int'(px_bus_pkg::SRC_AR);
			px_state_pkg::S_WW: return 4 + int'(px_bus_pkg::SRC_AR);
			px_state_pkg::S_I2,
			px_state_pkg::S_I3,
			px_state_pkg::S_I4: return 4 + int'(px_bus_pkg::SRC_STACK);	// Stack saves
			px_state_pkg::S_I5: return int'(px_bus_pkg::SRC_VECTOR);
			default:            return -1;
		endcase
	endfunction

	function automatic px_state_pkg::px_instr_t random_instr();
		px_state_pkg::px_instr_t d;
		d.arg = 1'($random(seed));
		d.op = px_state_pkg::px_mem_op_e'(2'($unsigned($random(seed)) % 3));	// No code 3
		return d;
	endfunction

	task automatic report_mismatch(input string what, input int exp, input int act);
		$display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error in %s: %s", cur_test, what);
		errors++;
	endtask

	task automatic apply_reset();
		clo_ = 1'b0;
		repeat (3) @(posedge got);
		@(negedge got);
		clo_ = 1'b1;
		exp_alarm = 1'b0;	// Flags clear only here
		exp_nomem = 1'b0;
	endtask

	// Length and strobe position of one finished state
	task automatic check_state(input px_state_pkg::px_state_e s, input int len,
			input int zg_cnt, input int ans_at, input int s1_at, input int s2_at, input bit tmo);
		int want;
		int lim;
		want = (s == px_state_pkg::S_K1) ? 2 : 3;	// Decode 2, acknowledge 3
		lim = int'(px_bus_pkg::BUS_TIMEOUT);
		if (expected_req(s) < 0) begin
			if (len != want) report_mismatch($sformatf("%s length", s.name()), want, len);
			if (s1_at != want) report_mismatch($sformatf("%s strob1 cycle", s.name()), want, s1_at);
			if (s2_at != -1) report_mismatch($sformatf("%s strob2 cycle", s.name()), -1, s2_at);
		end else if (tmo) begin
			if (zg_cnt != lim) report_mismatch($sformatf("%s zg cycles", s.name()), lim, zg_cnt);
			if (len != lim + 1) report_mismatch($sformatf("%s length", s.name()), lim + 1, len);
			if (s1_at != -1 || s2_at != -1) report_problem("strobe issued after a bus timeout");
		end else begin
			if (s1_at != ans_at + 1)
				report_mismatch($sformatf("%s strob1 cycle", s.name()), ans_at + 1, s1_at);
			if (s2_at != ans_at + 2)
				report_mismatch($sformatf("%s strob2 cycle", s.name()), ans_at + 2, s2_at);
			if (len != ans_at + 2) report_mismatch($sformatf("%s length", s.name()), ans_at + 2, len);
		end
	endtask

	// One start and/or irq, followed cycle by cycle until the unit is idle again
	task automatic run_sequence(input bit do_start, input px_state_pkg::px_instr_t desc,
			input bit do_irq);
		px_state_pkg::px_state_e exp_path[$];
		px_state_pkg::px_state_e cur;
		px_state_pkg::px_state_e fin_st;	// Where done belongs
		int idx, len, zg_cnt, ans_at, s1_at, s2_at, dly, n, done_cnt;
		bit tmo, tmo_seen, back;
		fin_st = px_state_pkg::S_IDLE;
		if (do_start) begin
			exp_path.push_back(px_state_pkg::S_P1);
			exp_path.push_back(px_state_pkg::S_K1);
			if (desc.arg) exp_path.push_back(px_state_pkg::S_K2);
			if (desc.op == px_state_pkg::OP_READ) exp_path.push_back(px_state_pkg::S_WR);
			if (desc.op == px_state_pkg::OP_WRITE) exp_path.push_back(px_state_pkg::S_WW);
			fin_st = exp_path[$];
		end
		if (do_irq) begin
			exp_path.push_back(px_state_pkg::S_I1);
			exp_path.push_back(px_state_pkg::S_I2);
			exp_path.push_back(px_state_pkg::S_I3);
			exp_path.push_back(px_state_pkg::S_I4);
			exp_path.push_back(px_state_pkg::S_I5);
		end
		@(negedge got);
		start = do_start;
		instr = desc;
		irq = do_irq & ~do_start;	// Alone it starts from idle
		cur = px_state_pkg::S_IDLE;
		idx = 0;
		done_cnt = 0;
		tmo = 1'b0;
		tmo_seen = 1'b0;
		back = 1'b0;
		for (n = 1; n <= 400 && !back; n++) begin
			@(negedge got);
			start = 1'b0;
			irq = 1'b0;
			ok = 1'b0;
			en = 1'b0;
			if (n == 2) begin
				start = 1'b1;	// Busy, must be ignored
				instr = random_instr();
				irq = do_irq & do_start;	// Lands inside the instruction
			end
			if (state != cur) begin
				if (cur != px_state_pkg::S_IDLE)
					check_state(cur, len, zg_cnt, ans_at, s1_at, s2_at, tmo);
				if (tmo && state != px_state_pkg::S_IDLE)
					report_mismatch("state after timeout", 0, int'(state));
				cur = state;
				if (cur == px_state_pkg::S_IDLE) begin
					back = 1'b1;
				end else begin
					if (idx >= exp_path.size())
						report_problem($sformatf("unexpected extra state %s", cur.name()));
					else if (exp_path[idx] != cur)
						report_mismatch($sformatf("path step %0d", idx), int'(exp_path[idx]),
							int'(cur));
					idx++;
					len = 0;
					zg_cnt = 0;
					ans_at = -1;
					s1_at = -1;
					s2_at = -1;
					dly = dly_lo + int'($unsigned($random(seed)) % (dly_hi - dly_lo + 1));
					tmo = (expected_req(cur) >= 0) && (dly >= int'(px_bus_pkg::BUS_TIMEOUT));
					tmo_seen |= tmo;
				end
			end
			if (!back && cur != px_state_pkg::S_IDLE) begin
				len++;
				if (!busy) report_mismatch($sformatf("%s busy", cur.name()), 1, 0);
				if (len == 1 && bus_req.zg != (expected_req(cur) >= 0))
					report_mismatch($sformatf("%s zg on entry", cur.name()),
						int'(expected_req(cur) >= 0), int'(bus_req.zg));
				if (bus_req.zg) begin
					if (zg_cnt == 0 && int'({bus_req.wr, bus_req.src}) != expected_req(cur))
						report_mismatch($sformatf("%s request", cur.name()), expected_req(cur),
							int'({bus_req.wr, bus_req.src}));
					if (zg_cnt == dly) begin
						ok = ~use_en;	// One-cycle answer
						en = use_en;
						exp_nomem |= use_en;
						ans_at = len;
					end
					zg_cnt++;
				end
				if (strob1) s1_at = len;
				if (strob2) s2_at = len;
				if (done) begin
					done_cnt++;
					if (cur != fin_st) report_mismatch("done state", int'(fin_st), int'(cur));
				end
			end
		end
		if (!back) report_problem("unit did not return to idle within 400 cycles");
		if (back && busy) report_mismatch("busy in idle", 0, 1);
		exp_alarm |= tmo_seen;
		if (!tmo_seen && idx != exp_path.size()) report_mismatch("path length", exp_path.size(), idx);
		if (done_cnt != ((do_start && !tmo_seen) ? 1 : 0))
			report_mismatch("done count", (do_start && !tmo_seen) ? 1 : 0, done_cnt);
		if (alarm != exp_alarm) report_mismatch("alarm", int'(exp_alarm), int'(alarm));
		if (nomem != exp_nomem) report_mismatch("nomem", int'(exp_nomem), int'(nomem));
	endtask

	task automatic close_test(input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_bad++;
			$display("test %s: failed with %0d errors", cur_test, errors - err_before);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	initial begin
		int e0;
		got = 1'b0;
		clo_ = 1'b0;
		start = 1'b0;
		instr = '0;
		irq = 1'b0;
		ok = 1'b0;
		en = 1'b0;
		use_en = 1'b0;
		dly_lo = 0;
		dly_hi = 2;	// Prompt answers
		apply_reset();

		cur_test = "reset";
		e0 = errors;
		if (state != px_state_pkg::S_IDLE)
			report_mismatch("state", int'(px_state_pkg::S_IDLE), int'(state));
		if ({busy, done, strob1, strob2, bus_req.zg, alarm, nomem} != 7'd0)
			report_mismatch("control outputs", 0,
				int'({busy, done, strob1, strob2, bus_req.zg, alarm, nomem}));
		close_test(e0);

		cur_test = "paths";
		e0 = errors;
		repeat (12) run_sequence(1'b1, random_instr(), 1'b0);
		close_test(e0);

		cur_test = "strobes";
		e0 = errors;
		dly_hi = 15;	// Slow, still inside the timeout
		repeat (6) run_sequence(1'b1, random_instr(), 1'b0);
		run_sequence(1'b0, '0, 1'b1);
		dly_hi = 2;
		close_test(e0);

		cur_test = "interrupts";
		e0 = errors;
		run_sequence(1'b0, '0, 1'b1);
		repeat (4) run_sequence(1'b1, random_instr(), 1'b1);
		close_test(e0);

		cur_test = "nomem";
		e0 = errors;
		use_en = 1'b1;
		run_sequence(1'b1, random_instr(), 1'b0);
		use_en = 1'b0;
		run_sequence(1'b1, random_instr(), 1'b0);	// Flag stays up
		close_test(e0);

		cur_test = "timeout";
		e0 = errors;
		dly_lo = 16;	// Never answered
		dly_hi = 20;
		run_sequence(1'b1, random_instr(), 1'b0);
		dly_lo = 0;
		dly_hi = 2;
		run_sequence(1'b1, random_instr(), 1'b0);
		close_test(e0);

		errors += px_i.sva_i.n_order + px_i.sva_i.n_zg + px_i.sva_i.n_done;
		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* verilog.f */
design/px_state_pkg.sv
design/px_bus_pkg.sv
design/px_state_reg.sv
design/px_irq_phase.sv
design/px_strobe.sv
design/px_bus_ctl.sv
design/px.sv
tb/px_sva.sv
tb/tb_px.sv
